//--- filelist.f
design/multipu_pkg.sv
design/pu.sv
design/pi1q.sv
design/multipu.sv
verif/mem_model.sv
verif/tb_multipu.sv

//--- run.sh
#!/bin/sh
# builds the cluster testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_multipu \
	-f filelist.f \
	-o tb_multipu
./obj_dir/tb_multipu

//--- verif/tb_multipu.sv
// --------------------------------------------------
// testbench for the multi-unit cluster
// loads random regions, starts the units and checks
// each result word against a reference sum
// --------------------------------------------------

`timescale 1ns/1ns

module tb_multipu;

	localparam int PUCOUNT = 4;
	localparam int JOBLEN  = 8;
	localparam int WORDS   = 1024;
	// cycles that any single wait may take
	localparam int TIMEOUT = 2000;
	localparam int RUNS    = 6;

	logic                                   clk_i;
	logic                                   arst_n_i;
	logic [PUCOUNT -1 : 0]                  start_i;
	logic [PUCOUNT -1 : 0]                  intrdy_o;
	logic [PUCOUNT -1 : 0]                  halted_o;
	logic [multipu_pkg::XADDRBITSZ -1 : 0]  rstaddr_i;
	logic [multipu_pkg::XADDRBITSZ -1 : 0]  rstaddr2_i;
	logic [multipu_pkg::XARCHBITSZ -1 : 0]  id_i;
	multipu_pkg::pi1_req_t                  pi1_req;
	multipu_pkg::pi1_rsp_t                  pi1_rsp;
	logic [2:0]                             max_wait;
	logic                                   mem_err;

	// copy of the loaded words, expected results, per unit bookkeeping
	logic [31:0]            shadow [WORDS];
	logic [31:0]            exp_word [PUCOUNT];
	logic [PUCOUNT -1 : 0]  armed;
	logic [PUCOUNT -1 : 0]  done_mask;
	logic [PUCOUNT -1 : 0]  halted_q;

	multipu #(
		.PUCOUNT (PUCOUNT),
		.JOBLEN  (JOBLEN)
	) dut_i (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.start_i    (start_i),
		.intrdy_o   (intrdy_o),
		.halted_o   (halted_o),
		.rstaddr_i  (rstaddr_i),
		.rstaddr2_i (rstaddr2_i),
		.id_i       (id_i),
		.pi1_req_o  (pi1_req),
		.pi1_rsp_i  (pi1_rsp)
	);

	mem_model #(.WORDS(WORDS)) mem_i (
		.clk_i      (clk_i),
		.req_i      (pi1_req),
		.max_wait_i (max_wait),
		.rsp_o      (pi1_rsp),
		.err_o      (mem_err)
	);

	always #2 clk_i = ~clk_i;

	// unit 0 at rstaddr_i, the others packed after rstaddr2_i with their result words
	function automatic int unsigned region_base(input int k);
		if (k == 0)
			return 32'(rstaddr_i);
		return 32'(rstaddr2_i) + (k - 1) * (JOBLEN + 1);
	endfunction

	// wrap-around sum of the region, then xor with the unit id
	function automatic logic [31:0] ref_result(input int k);
		logic [31:0] sum;
		sum = '0;
		for (int j = 0; j < JOBLEN; j++)
			sum = sum + shadow[region_base(k) + j];
		return sum ^ (id_i + 32'(k));
	endfunction

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	// new regions and id, start strobe, then wait for every armed unit to be checked
	task automatic run_job(input logic [PUCOUNT -1 : 0] mask);
		int unsigned base;
		int          n;
		rstaddr_i  = 30'($urandom_range(255, 0));
		rstaddr2_i = 30'($urandom_range(767, 512));
		id_i       = $urandom;
		mem_i.clear_map();
		for (int k = 0; k < PUCOUNT; k++) begin
			if (mask[k]) begin
				base = region_base(k);
				for (int j = 0; j < JOBLEN; j++) begin
					shadow[base + j] = $urandom;
					mem_i.set_word(base + j, shadow[base + j], 1'b0);
				end
				exp_word[k] = ref_result(k);
				// poisoned result word so a lost write shows up
				mem_i.set_word(base + JOBLEN, ~exp_word[k], 1'b1);
			end
		end
		armed     = mask;
		done_mask = '0;
		start_i   = mask;
		@(negedge clk_i);
		start_i = '0;
		n = 0;
		while ((done_mask & mask) != mask) begin
			@(negedge clk_i);
			n++;
			assert (n < TIMEOUT) else stop_with_fail($sformatf(
				"timeout: units 0x%0h did not halt within %0d cycles", mask & ~done_mask, TIMEOUT));
		end
	endtask

	// compares a result word as soon as its unit reports halted
	always @(negedge clk_i) begin
		logic [31:0] got;
		for (int k = 0; k < PUCOUNT; k++) begin
			if (armed[k] && halted_o[k] && !halted_q[k]) begin
				got = mem_i.get_word(region_base(k) + JOBLEN);
				assert (got == exp_word[k]) else stop_with_fail($sformatf(
					"[FAIL] %0t ns: unit %0d wrote 0x%08h, expected 0x%08h",
					$time, k, got, exp_word[k]));
				assert (intrdy_o[k]) else stop_with_fail($sformatf(
					"[FAIL] %0t ns: unit %0d halted with intrdy_o low", $time, k));
				done_mask[k] = 1'b1;
			end
		end
		halted_q = halted_o;
	end

	always @(posedge mem_err)
		stop_with_fail("the memory model saw an illegal bus access");

	initial begin
		void'($urandom(565));
		clk_i      = 1'b0;
		arst_n_i   = 1'b0;
		start_i    = '0;
		rstaddr_i  = '0;
		rstaddr2_i = '0;
		id_i       = '0;
		max_wait   = '0;
		armed      = '0;
		done_mask  = '0;
		halted_q   = '0;
		mem_i.clear_map();
		repeat (4) @(negedge clk_i);
		arst_n_i = 1'b1;
		@(negedge clk_i);
		assert (intrdy_o == '1 && halted_o == '0 && pi1_req.op == multipu_pkg::PI1_NONE)
			else stop_with_fail($sformatf("[FAIL] %0t ns: outputs not idle after reset", $time));
		// unit 0 alone, no wait states
		run_job(PUCOUNT'(1));
		// all units on the same cycle, arbitration only
		run_job('1);
		// back-pressure, fresh regions and ids on every run
		max_wait = 3'd5;
		run_job('1);
		for (int r = 0; r < RUNS; r++)
			run_job(PUCOUNT'($urandom_range(2 ** PUCOUNT - 1, 1)));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verif/mem_model.sv
// --------------------------------------------------
// pi1 slave memory for the cluster testbench
// answers after a random number of wait cycles and
// flags any access outside the loaded regions
// --------------------------------------------------

`timescale 1ns/1ns

module mem_model #(
	parameter int WORDS = 1024
) (
	input  logic                   clk_i,
	input  multipu_pkg::pi1_req_t  req_i,
	input  logic [2:0]             max_wait_i,
	output multipu_pkg::pi1_rsp_t  rsp_o,
	output logic                   err_o
);

	logic [multipu_pkg::XARCHBITSZ -1 : 0]  mem [WORDS];
	// access rights per word
	logic                                   rd_ok [WORDS];
	logic                                   wr_ok [WORDS];
	int unsigned                            wait_cnt;

	// forbid every word, data from a pattern over the whole address
	task automatic clear_map();
		for (int a = 0; a < WORDS; a++) begin
			mem[a]   = 32'(a) * 32'h9e37_79b1;
			rd_ok[a] = 1'b0;
			wr_ok[a] = 1'b0;
		end
	endtask

	// region words are read only, result words write only
	task automatic set_word(input int unsigned addr, input logic [31:0] data, input logic result);
		mem[addr]   = data;
		rd_ok[addr] = !result;
		wr_ok[addr] = result;
	endtask

	function automatic logic [31:0] get_word(input int unsigned addr);
		return mem[addr];
	endfunction

	task automatic bus_error(input string what);
		$display("mem_model: %s, address 0x%0h at %0t ns", what, req_i.addr, $time);
		err_o = 1'b1;
	endtask

	initial begin
		rsp_o    = '0;
		err_o    = 1'b0;
		wait_cnt = 0;
	end

	// slave works on the falling edge, the DUT samples rdy half a cycle later
	always @(negedge clk_i) begin
		int unsigned a;
		a = 32'(req_i.addr);
		if (rsp_o.rdy) begin
			// rdy lasts one cycle, the arbiter has dropped op by now
			rsp_o.rdy = 1'b0;
		end else if (req_i.op != multipu_pkg::PI1_NONE) begin
			if (wait_cnt != 0) begin
				wait_cnt = wait_cnt - 1;
			end else begin
				assert (req_i.sel == '1) else bus_error("sel is not all ones");
				case (req_i.op)
				multipu_pkg::PI1_READ: begin
					assert (a < WORDS && rd_ok[a % WORDS])
						else bus_error("read of a result word or outside the regions");
					rsp_o.data = mem[a % WORDS];
				end
				multipu_pkg::PI1_WRITE: begin
					assert (a < WORDS && wr_ok[a % WORDS])
						else bus_error("write outside the result words");
					mem[a % WORDS] = req_i.data;
				end
				default: bus_error("unsupported bus operation");
				endcase
				rsp_o.rdy = 1'b1;
				// back-pressure for the next access
				wait_cnt = $urandom_range(32'(max_wait_i), 0);
			end
		end
	end

endmodule

//--- design/multipu.sv
// --------------------------------------------------
// top level of the multi-unit cluster
// generates PUCOUNT units and queues their pi1
// traffic onto a single master port toward the
// external memory; everything runs on clk_i
// --------------------------------------------------

`timescale 1ns/1ns

module multipu #(
	parameter int PUCOUNT = 4,
	parameter int JOBLEN  = 8
) (
	input  logic                                   clk_i,
	input  logic                                   arst_n_i,
	input  logic [PUCOUNT -1 : 0]                  start_i,
	output logic [PUCOUNT -1 : 0]                  intrdy_o,
	output logic [PUCOUNT -1 : 0]                  halted_o,
	input  logic [multipu_pkg::XADDRBITSZ -1 : 0]  rstaddr_i,
	input  logic [multipu_pkg::XADDRBITSZ -1 : 0]  rstaddr2_i,
	input  logic [multipu_pkg::XARCHBITSZ -1 : 0]  id_i,
	output multipu_pkg::pi1_req_t                  pi1_req_o,
	input  multipu_pkg::pi1_rsp_t                  pi1_rsp_i
);

	// per-unit bus between the units and the arbiter
	multipu_pkg::pi1_req_t  m_req_w [PUCOUNT];
	multipu_pkg::pi1_rsp_t  m_rsp_w [PUCOUNT];

	// each unit works out its own region and id from PUID,
	// so both reset addresses and id_i go to all of them as is
	for (genvar gi = 0; gi < PUCOUNT; gi++) begin : gen_pu
		pu #(
			.PUID   (gi),
			.JOBLEN (JOBLEN)
		) pu_i (
			.clk_i      (clk_i),
			.arst_n_i   (arst_n_i),
			.start_i    (start_i[gi]),
			.rstaddr_i  (rstaddr_i),
			.rstaddr2_i (rstaddr2_i),
			.id_i       (id_i),
			.intrdy_o   (intrdy_o[gi]),
			.halted_o   (halted_o[gi]),
			.pi1_req_o  (m_req_w[gi]),
			.pi1_rsp_i  (m_rsp_w[gi])
		);
	end

	// the arbiter slave port is the cluster's master port, no extra stage
	pi1q #(
		.PUCOUNT (PUCOUNT)
	) pi1q_i (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.m_req_i  (m_req_w),
		.m_rsp_o  (m_rsp_w),
		.s_req_o  (pi1_req_o),
		.s_rsp_i  (pi1_rsp_i)
	);

endmodule

//--- design/pi1q.sv
// --------------------------------------------------
// round-robin pi1 arbiter
// queues PUCOUNT masters onto one slave port; the
// granted request is registered and held until the
// slave answers, the response goes to its owner only
// --------------------------------------------------

`timescale 1ns/1ns

module pi1q #(
	parameter int PUCOUNT = 4
) (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  multipu_pkg::pi1_req_t  m_req_i [PUCOUNT],
	output multipu_pkg::pi1_rsp_t  m_rsp_o [PUCOUNT],
	output multipu_pkg::pi1_req_t  s_req_o,
	input  multipu_pkg::pi1_rsp_t  s_rsp_i
);

	localparam int IDXW = (PUCOUNT > 1) ? $clog2(PUCOUNT) : 1;

	logic                   busy_q;
	logic [IDXW -1 : 0]     gnt_q;
	logic [IDXW -1 : 0]     rr_q;
	multipu_pkg::pi1_req_t  s_req_q;
	logic                   nxt_found;
	logic [IDXW -1 : 0]     nxt_idx;
	logic [PUCOUNT -1 : 0]  gnt_vec;

	// next requester after the last one served, wrapping around
	always_comb begin
		int unsigned k;
		nxt_found = 1'b0;
		nxt_idx   = rr_q;
		for (int i = 1; i <= PUCOUNT; i++) begin
			k = int'(rr_q) + i;
			if (k >= PUCOUNT)
				k = k - PUCOUNT;
			if (!nxt_found && m_req_i[k].op != multipu_pkg::PI1_NONE) begin
				nxt_found = 1'b1;
				nxt_idx   = IDXW'(k);
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q  <= 1'b0;
			gnt_q   <= '0;
			// first grant lands on master 0
			rr_q    <= IDXW'(PUCOUNT - 1);
			s_req_q <= '0;
		end else if (!busy_q) begin
			// grant now, request shows on the slave port next cycle
			if (nxt_found) begin
				busy_q  <= 1'b1;
				gnt_q   <= nxt_idx;
				s_req_q <= m_req_i[nxt_idx];
			end
		end else if (s_rsp_i.rdy) begin
			// one idle cycle on the slave port before the next grant
			busy_q     <= 1'b0;
			rr_q       <= gnt_q;
			s_req_q.op <= multipu_pkg::PI1_NONE;
		end
	end

	assign s_req_o = s_req_q;

	// response back to the owner only, everyone else sees zeros
	always_comb begin
		for (int i = 0; i < PUCOUNT; i++) begin
			gnt_vec[i] = busy_q && (gnt_q == IDXW'(i));
			m_rsp_o[i] = '0;
			if (gnt_vec[i])
				m_rsp_o[i] = s_rsp_i;
		end
	end

	// exactly one owner while busy or answered, and it is still holding its request
	// a slave rdy with no grant held would be lost
	a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(busy_q || s_rsp_i.rdy) |-> ($onehot(gnt_vec) && m_req_i[gnt_q] == s_req_q))
		else $error("pi1q: rdy without a single owner or owner dropped its request");

	// swap ops are not supported by this cluster
	a_no_rdwr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		s_req_q.op != multipu_pkg::PI1_RDWR)
		else $error("pi1q: PI1_RDWR on the slave port");

	a_s_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(s_req_q.op != multipu_pkg::PI1_NONE && !s_rsp_i.rdy) |=> $stable(s_req_q))
		else $error("pi1q: slave request changed before rdy");

endmodule

//--- design/pu.sv
// --------------------------------------------------
// one processing unit of the cluster
// on a start strobe it reads JOBLEN words from its
// region, sums them, xors in its id and writes the
// result to the word after the region, then halts
// --------------------------------------------------

`timescale 1ns/1ns

module pu #(
	parameter int PUID   = 0,
	parameter int JOBLEN = 8
) (
	input  logic                                     clk_i,
	input  logic                                     arst_n_i,
	input  logic                                     start_i,
	input  logic [multipu_pkg::XADDRBITSZ -1 : 0]    rstaddr_i,
	input  logic [multipu_pkg::XADDRBITSZ -1 : 0]    rstaddr2_i,
	input  logic [multipu_pkg::XARCHBITSZ -1 : 0]    id_i,
	output logic                                     intrdy_o,
	output logic                                     halted_o,
	output multipu_pkg::pi1_req_t                    pi1_req_o,
	input  multipu_pkg::pi1_rsp_t                    pi1_rsp_i
);

	// word counter wide enough for JOBLEN-1
	localparam int CNTW = (JOBLEN > 1) ? $clog2(JOBLEN) : 1;

	// offset of this unit inside the rstaddr2_i area, each region plus its result word
	localparam int OFFS = (PUID == 0) ? 0 : (PUID - 1) * (JOBLEN + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_DONE
	} state_e;

	state_e                                 state_q;
	logic [CNTW -1 : 0]                     cnt_q;
	logic [multipu_pkg::XADDRBITSZ -1 : 0]  addr_q;
	logic [multipu_pkg::XARCHBITSZ -1 : 0]  sum_q;
	logic [multipu_pkg::XADDRBITSZ -1 : 0]  start_addr;
	logic [multipu_pkg::XARCHBITSZ -1 : 0]  unit_id;
	logic                                   go;
	logic                                   last_rd;

	// unit 0 boots from rstaddr_i, the others are packed after rstaddr2_i
	assign start_addr = (PUID == 0) ? rstaddr_i :
		rstaddr2_i + multipu_pkg::XADDRBITSZ'(OFFS);
	assign unit_id = id_i + multipu_pkg::XARCHBITSZ'(PUID);

	// ready for a new job in idle and once halted
	assign intrdy_o = (state_q == ST_IDLE) || (state_q == ST_DONE);
	assign halted_o = (state_q == ST_DONE);

	// start only counts while ready
	assign go = intrdy_o && start_i;
	assign last_rd = (cnt_q == CNTW'(JOBLEN - 1));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
			ST_IDLE, ST_DONE: begin
				if (start_i) begin
					state_q <= ST_READ;
					cnt_q   <= '0;
				end
			end
			ST_READ: begin
				// one word per rdy, last one moves on to the write
				if (pi1_rsp_i.rdy) begin
					cnt_q <= cnt_q + 1'b1;
					if (last_rd)
						state_q <= ST_WRITE;
				end
			end
			ST_WRITE: begin
				if (pi1_rsp_i.rdy)
					state_q <= ST_DONE;
			end
			default: state_q <= ST_IDLE;
			endcase
		end
	end

	// address and running sum, loaded on start
	// after the last read addr_q already points at the result word
	always_ff @(posedge clk_i) begin
		if (go) begin
			addr_q <= start_addr;
			sum_q  <= '0;
		end else if (state_q == ST_READ && pi1_rsp_i.rdy) begin
			addr_q <= addr_q + 1'b1;
			sum_q  <= sum_q + pi1_rsp_i.data;
		end
	end

	// request is a pure decode of the registered state
	always_comb begin
		pi1_req_o     = '0;
		pi1_req_o.sel = '1;
		case (state_q)
		ST_READ: begin
			pi1_req_o.op   = multipu_pkg::PI1_READ;
			pi1_req_o.addr = addr_q;
		end
		ST_WRITE: begin
			pi1_req_o.op   = multipu_pkg::PI1_WRITE;
			pi1_req_o.addr = addr_q;
			pi1_req_o.data = sum_q ^ unit_id;
		end
		default: ;
		endcase
	end

	// an open request must not move before the arbiter answers it
	a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(pi1_req_o.op != multipu_pkg::PI1_NONE && !pi1_rsp_i.rdy) |=> $stable(pi1_req_o))
		else $error("pu %0d: request changed before rdy", PUID);

	// the arbiter only routes rdy back to the owner of an open request
	a_rdy_owned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		pi1_rsp_i.rdy |-> (pi1_req_o.op != multipu_pkg::PI1_NONE))
		else $error("pu %0d: rdy without a request", PUID);

endmodule

//--- design/multipu_pkg.sv
// --------------------------------------------------
// shared definitions for the multi-unit cluster
// pi1 bus widths, op encoding and the request and
// response structs that travel between the units,
// the arbiter and the external memory port
// --------------------------------------------------

package multipu_pkg;

	// data width of one bus word
	localparam int XARCHBITSZ = 32;

	// byte lanes per word
	localparam int SELBITSZ = XARCHBITSZ / 8;

	// word address, byte offset bits dropped
	localparam int XADDRBITSZ = XARCHBITSZ - $clog2(SELBITSZ);

	// pi1 operations
	// rdwr is the swap op of the full bus, never issued by this cluster
	typedef enum logic [1:0] {
		PI1_NONE  = 2'd0,
		PI1_WRITE = 2'd1,
		PI1_READ  = 2'd2,
		PI1_RDWR  = 2'd3
	} pi1_op_e;

	// master side of the bus
	// held stable from op raised until rdy seen
	typedef struct packed {
		pi1_op_e                   op;
		logic [XADDRBITSZ -1 : 0]  addr;
		logic [XARCHBITSZ -1 : 0]  data;
		logic [SELBITSZ -1 : 0]    sel;
	} pi1_req_t;

	// slave side of the bus
	// data is only meaningful on the rdy cycle of a read
	typedef struct packed {
		logic [XARCHBITSZ -1 : 0]  data;
		logic                      rdy;
	} pi1_rsp_t;

endpackage
